//--- Makefile
# Verilator lint, simulation and clean for the receiver front end

TOP := rx_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o rx_sim
	./obj_dir/rx_sim | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- adc_monitor.sv
// ADC monitor with level/overflow counter and masked overflow window reporter
`include "rx_settings.svh"

module adc_monitor (
    input  logic                       adc_clk,
    input  logic                       rst_n,
    input  rx_types_pkg::adc_sample_t  adc_data,
    input  logic                       adc_ovfl,
    input  logic                       reg_wr,
    input  rx_regs_pkg::reg_addr_t     reg_addr,
    input  logic [31:0]                reg_wdata,
    input  logic                       report_ready,
    output logic                       report_valid,
    output rx_types_pkg::ovfl_report_t report_data,
    output logic [31:0]                adc_count
);
    import rx_types_pkg::*;
    import rx_regs_pkg::*;

    localparam int WIN_BITS = `RX_OVFL_WIN_BITS;

    adc_sample_t               adc_neg;
    adc_mag_t                  adc_mag;
    adc_mag_t                  level_q;
    level_mode_t               mode_q;
    ovfl_cnt_t                 mask_q;
    logic                      wr_level;
    logic                      wr_mask;
    logic                      wr_clear;
    logic [WIN_BITS-1:0]       win_cnt;
    ovfl_cnt_t                 ovfl_sum;
    ovfl_cnt_t                 win_total;
    logic [7:0]                seq_q;
    logic                      report_pend;

    // own address decode
    assign wr_level = reg_wr && (reg_addr == REG_LEVEL);
    assign wr_mask  = reg_wr && (reg_addr == REG_OVFL_MASK);
    assign wr_clear = reg_wr && (reg_addr == REG_CLEAR);

    //////////////////////////////////////////////////////////////////////
    // magnitude and level counter
    //////////////////////////////////////////////////////////////////////

    // negating the most negative code wraps back to itself, so clamp it
    assign adc_neg = -adc_data;
    always_comb
    begin
        if (adc_data == {1'b1, {(`RX_ADC_BITS-1){1'b0}}})
            adc_mag = '1;
        else if (adc_data[`RX_ADC_BITS-1])
            adc_mag = adc_neg[`RX_ADC_BITS-2:0];
        else
            adc_mag = adc_data[`RX_ADC_BITS-2:0];
    end

    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            level_q <= '1;
            mode_q  <= LVL_MAG;
            mask_q  <= '1;
        end
        else
        begin
            if (wr_level)
            begin
                level_q <= reg_wdata[`RX_ADC_BITS-2:0];
                mode_q  <= level_mode_t'(reg_wdata[LEVEL_MODE_BIT]);
            end
            if (wr_mask)
                mask_q <= reg_wdata[WIN_BITS:0];
        end
    end

    // a level or clear write restarts the count and skips this sample
    always_ff @(posedge adc_clk)
    begin
        if (!rst_n || wr_level || wr_clear)
            adc_count <= '0;
        else if (mode_q == LVL_MAG && adc_mag >= level_q)
            adc_count <= adc_count + 32'd1;
        else if (mode_q == LVL_OVFL && adc_ovfl)
            adc_count <= adc_count + 32'd1;
    end

    //////////////////////////////////////////////////////////////////////
    // overflow window
    //////////////////////////////////////////////////////////////////////

    // running count including the flag of the current sample
    assign win_total = ovfl_sum + ovfl_cnt_t'(adc_ovfl);

    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            win_cnt     <= '0;
            ovfl_sum    <= '0;
            seq_q       <= '0;
            report_pend <= 1'b0;
        end
        else
        begin
            win_cnt     <= win_cnt + 1'b1;
            report_pend <= 1'b0;
            if (&win_cnt)
            begin
                // last sample closes the window
                ovfl_sum    <= '0;
                seq_q       <= seq_q + 8'd1;
                report_pend <= (win_total & mask_q) != '0;
                report_data <= '{seq_num: seq_q, ovfl_cnt: win_total};
            end
            else
                ovfl_sum <= win_total;
        end
    end

    // report is only offered when the FIFO has room, otherwise it is lost
    assign report_valid = report_pend && report_ready;

endmodule

//--- decim_accum.sv
// accumulate-and-dump decimator with programmable ratio and saturating drop counter
`include "rx_settings.svh"

module decim_accum (
    input  logic                      adc_clk,
    input  logic                      rst_n,
    input  rx_types_pkg::adc_sample_t adc_data,
    input  logic                      reg_wr,
    input  rx_regs_pkg::reg_addr_t    reg_addr,
    input  logic [31:0]               reg_wdata,
    input  logic                      sum_ready,
    output logic                      sum_valid,
    output rx_types_pkg::decim_sum_t  sum_data,
    output logic [15:0]               drop_count
);
    import rx_types_pkg::*;
    import rx_regs_pkg::*;

    localparam int RATIO_BITS = $clog2(`RX_DECIM_MAX);
    localparam int EXT_BITS   = $bits(decim_sum_t) - $bits(adc_sample_t);

    logic                  wr_decim;
    logic [RATIO_BITS-1:0] ratio_q;
    logic [RATIO_BITS-1:0] phase_q;
    decim_sum_t            samp_ext;
    decim_sum_t            acc_q;
    decim_sum_t            acc_next;

    assign wr_decim = reg_wr && (reg_addr == REG_DECIM);

    // sign extend into the guard bits
    assign samp_ext = {{EXT_BITS{adc_data[`RX_ADC_BITS-1]}}, adc_data};

    // phase zero starts a fresh sum from the current sample
    assign acc_next = (phase_q == '0) ? samp_ext : acc_q + samp_ext;

    //////////////////////////////////////////////////////////////////////
    // accumulate and dump
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            ratio_q   <= '0;
            phase_q   <= '0;
            sum_valid <= 1'b0;
        end
        else if (wr_decim)
        begin
            // new ratio, accumulation restarts with the next sample
            ratio_q   <= reg_wdata[RATIO_BITS-1:0];
            phase_q   <= '0;
            sum_valid <= 1'b0;
        end
        else
        begin
            // valid lasts one cycle per dump
            sum_valid <= (phase_q == ratio_q);
            if (phase_q == ratio_q)
                phase_q <= '0;
            else
                phase_q <= phase_q + 1'b1;
        end
    end

    // holds the finished sum in the cycle after the dump
    always_ff @(posedge adc_clk)
    begin
        acc_q <= acc_next;
    end

    assign sum_data = acc_q;

    //////////////////////////////////////////////////////////////////////
    // drop counter
    //////////////////////////////////////////////////////////////////////

    // sum is not held, a busy FIFO means it is gone
    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
            drop_count <= '0;
        else if (sum_valid && !sum_ready && drop_count != '1)
            drop_count <= drop_count + 16'd1;
    end

endmodule

//--- project.f
+incdir+.
rx_types_pkg.sv
rx_regs_pkg.sv
adc_monitor.sv
decim_accum.sv
stream_fifo.sv
rx_top.sv
rx_sva.sv
rx_tb.sv

//--- rx_regs_pkg.sv
// register map and level counter mode encoding
package rx_regs_pkg;

    //////////////////////////////////////////////////////////////////////
    // write port addresses
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        // level threshold in the low bits, mode in LEVEL_MODE_BIT
        REG_LEVEL     = 3'd0,
        // mask applied to each window overflow count
        REG_OVFL_MASK = 3'd1,
        // decimation ratio minus one
        REG_DECIM     = 3'd2,
        // any write zeroes the level counter
        REG_CLEAR     = 3'd3
    } reg_addr_t;

    //////////////////////////////////////////////////////////////////////
    // level counter mode
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        LVL_MAG  = 1'b0,
        LVL_OVFL = 1'b1
    } level_mode_t;

    // mode bit position in the REG_LEVEL write data
    localparam int LEVEL_MODE_BIT = 16;

endpackage

//--- rx_settings.svh
// build constants for the receiver front end: ADC width, overflow window, FIFO depths, decimation
`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// converter
//////////////////////////////////////////////////////////////////////

// width of one signed ADC sample
`define RX_ADC_BITS 14

// log2 of the overflow window length in samples
// kept short here so windows close quickly, the full design runs 16
`define RX_OVFL_WIN_BITS 6

//////////////////////////////////////////////////////////////////////
// decimation and output buffering
//////////////////////////////////////////////////////////////////////

// largest accumulate-and-dump ratio
`define RX_DECIM_MAX 16

// entries in the decimated sample FIFO
`define RX_SAMP_FIFO_DEPTH 8

// entries in the overflow report FIFO
`define RX_STAT_FIFO_DEPTH 4

`endif

//--- rx_sva.sv
// bound assertions on rx_top reset outputs, output stream handshakes and the drop counter
module rx_sva (
    input logic                       adc_clk,
    input logic                       rst_n,
    input logic                       samp_valid,
    input logic                       samp_ready,
    input rx_types_pkg::decim_sum_t   samp_data,
    input logic                       stat_valid,
    input logic                       stat_ready,
    input rx_types_pkg::ovfl_report_t stat_data,
    input logic [15:0]                drop_count
);

    // a reset edge empties both FIFOs
    a_reset_quiet: assert property (@(posedge adc_clk)
        !rst_n |=> !samp_valid && !stat_valid)
        else $error("output valid high after a reset edge");

    // stalled outputs keep their item
    a_samp_hold: assert property (@(posedge adc_clk) disable iff (!rst_n)
        samp_valid && !samp_ready |=> samp_valid && $stable(samp_data))
        else $error("samp_data changed while stalled");

    a_stat_hold: assert property (@(posedge adc_clk) disable iff (!rst_n)
        stat_valid && !stat_ready |=> stat_valid && $stable(stat_data))
        else $error("stat_data changed while stalled");

    // saturating counter, never wraps back
    a_drop_mono: assert property (@(posedge adc_clk) disable iff (!rst_n)
        rst_n |=> drop_count >= $past(drop_count))
        else $error("drop_count decreased");

endmodule

bind rx_top rx_sva sva0 (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .samp_valid (samp_valid),
    .samp_ready (samp_ready),
    .samp_data  (samp_data),
    .stat_valid (stat_valid),
    .stat_ready (stat_ready),
    .stat_data  (stat_data),
    .drop_count (drop_count)
);

//--- rx_tb.sv
// testbench for rx_top: clock, reset, LCG stimulus, cycle model, checks and summary
`include "rx_settings.svh"

module rx_tb;
    import rx_types_pkg::*;
    import rx_regs_pkg::*;

    localparam int          WIN_LEN = 1 << `RX_OVFL_WIN_BITS;
    localparam int          MAG_MAX = (1 << (`RX_ADC_BITS - 1)) - 1;
    localparam logic [31:0] SEED    = 32'h90fee45f;

    logic         adc_clk;
    logic         rst_n;
    adc_sample_t  adc_data;
    logic         adc_ovfl;
    logic         reg_wr;
    reg_addr_t    reg_addr;
    logic [31:0]  reg_wdata;
    logic         samp_valid;
    logic         samp_ready;
    decim_sum_t   samp_data;
    logic         stat_valid;
    logic         stat_ready;
    ovfl_report_t stat_data;
    logic [31:0]  adc_count;
    logic [15:0]  drop_count;

    // stimulus controls, changed on the falling edge only
    logic [31:0]  stim_state   = SEED;
    logic [31:0]  ovfl_thresh  = '0;
    logic         ready_random = 1'b0;
    logic         stat_random  = 1'b0;
    logic         allow_skip   = 1'b0;

    // model state, updated on the falling edge for the coming rising edge
    adc_mag_t     m_level;
    level_mode_t  m_mode;
    ovfl_cnt_t    m_mask;
    logic [31:0]  exp_count;
    int           win_pos;
    ovfl_cnt_t    win_sum;
    logic [7:0]   win_seq;
    int           dec_ratio;
    int           dec_phase;
    decim_sum_t   dec_acc;
    decim_sum_t   sum_q[$];
    ovfl_report_t rep_q[$];
    logic [15:0]  drop_seen = '0;

    int errors       = 0;
    int err_mark     = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int made         = 0;
    int accepted     = 0;
    int ratios[3]    = '{1, 5, 16};

    rx_top dut0 (.*);

    initial
    begin
        adc_clk = 1'b0;
        forever #50 adc_clk = ~adc_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // absolute value, most negative code clamps to full scale
    function automatic int abs_saturated(adc_sample_t s);
        int v;
        v = (s < 0) ? -int'(s) : int'(s);
        return (v > MAG_MAX) ? MAG_MAX : v;
    endfunction

    task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(string msg);
        errors++;
        $display("Failure at time %0t: %s", $time, msg);
    endtask

    // one cycle write strobe, acts on the second rising edge
    task automatic write_reg(reg_addr_t addr, logic [31:0] data);
        @(posedge adc_clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge adc_clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic set_stim(logic [31:0] thresh, logic rnd);
        @(negedge adc_clk);
        ovfl_thresh  = thresh;
        ready_random = rnd;
    endtask

    task automatic wait_accepted(int target);
        int n;
        n = 0;
        while (accepted < target && n < 40 * `RX_DECIM_MAX)
        begin
            @(posedge adc_clk);
            n++;
        end
        if (accepted < target)
            report_failure("timeout waiting for decimated samples");
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors != err_mark)
            tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // under back-pressure dropped sums are skipped, order still holds
    task automatic take_sample(decim_sum_t got);
        accepted++;
        if (!allow_skip)
        begin
            if (sum_q.size() == 0)
                report_failure("sample accepted while no model sum was pending");
            else
                check_value("samp_data", got, sum_q.pop_front());
        end
        else
        begin
            while (sum_q.size() > 0 && sum_q[0] !== got)
                void'(sum_q.pop_front());
            if (sum_q.size() == 0)
                report_failure("accepted sample matches no later model sum");
            else
                void'(sum_q.pop_front());
        end
    endtask

    task automatic take_report(ovfl_report_t got);
        if (rep_q.size() == 0)
            report_failure("overflow report arrived for a window that expects none");
        else
            check_value("stat_data", got, rep_q.pop_front());
    endtask

    task automatic step_model();
        // a level or clear write wins over the sample of the same edge
        if (reg_wr && (reg_addr == REG_LEVEL || reg_addr == REG_CLEAR))
            exp_count = '0;
        else if ((m_mode == LVL_MAG) ? (abs_saturated(adc_data) >= m_level) : adc_ovfl)
            exp_count++;
        // window closes with the mask in force before any write
        win_sum += adc_ovfl;
        if (win_pos == WIN_LEN - 1)
        begin
            if ((win_sum & m_mask) != '0)
                rep_q.push_back(ovfl_report_t'{seq_num: win_seq, ovfl_cnt: win_sum});
            win_seq++;
            win_sum = '0;
            win_pos = 0;
        end
        else
            win_pos++;
        // ratio write drops the partial sum and this sample
        if (reg_wr && reg_addr == REG_DECIM)
        begin
            dec_ratio = int'(reg_wdata[3:0]) + 1;
            dec_phase = 0;
            dec_acc   = '0;
        end
        else
        begin
            dec_acc += adc_data;
            dec_phase++;
            if (dec_phase == dec_ratio)
            begin
                sum_q.push_back(dec_acc);
                made++;
                dec_phase = 0;
                dec_acc   = '0;
            end
        end
        if (reg_wr && reg_addr == REG_LEVEL)
        begin
            m_level = reg_wdata[`RX_ADC_BITS-2:0];
            m_mode  = level_mode_t'(reg_wdata[LEVEL_MODE_BIT]);
        end
        if (reg_wr && reg_addr == REG_OVFL_MASK)
            m_mask = reg_wdata[`RX_OVFL_WIN_BITS:0];
    endtask

    // falling edge sees stable outputs and the inputs of the next edge
    always @(negedge adc_clk)
    begin
        if (!rst_n)
        begin
            m_level   = '1;
            m_mode    = LVL_MAG;
            m_mask    = '1;
            exp_count = '0;
            win_pos   = 0;
            win_sum   = '0;
            win_seq   = '0;
            dec_ratio = 1;
            dec_phase = 0;
            dec_acc   = '0;
        end
        else
        begin
            drop_seen = drop_count;
            check_value("adc_count", adc_count, exp_count);
            if (samp_valid && samp_ready)
                take_sample(samp_data);
            if (stat_valid && stat_ready)
                take_report(stat_data);
            step_model();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus and test sequence
    //////////////////////////////////////////////////////////////////////

    always @(posedge adc_clk)
    begin
        stim_state = lcg_step(stim_state);
        adc_data   <= stim_state[31:18];
        stim_state = lcg_step(stim_state);
        adc_ovfl   <= (stim_state < ovfl_thresh);
        stim_state = lcg_step(stim_state);
        samp_ready <= ready_random ? stim_state[31] : 1'b1;
        stat_ready <= stat_random ? stim_state[30] : 1'b1;
    end

    initial
    begin
        logic [31:0] cfg;
        int          t0;
        cfg        = ~SEED;
        rst_n      = 1'b0;
        adc_data   = '0;
        adc_ovfl   = 1'b0;
        reg_wr     = 1'b0;
        reg_addr   = REG_LEVEL;
        reg_wdata  = '0;
        samp_ready = 1'b1;
        stat_ready = 1'b1;
        repeat (4) @(posedge adc_clk);
        rst_n <= 1'b1;

        // level count with random thresholds, then clear
        for (int i = 0; i < 2; i++)
        begin
            cfg = lcg_step(cfg);
            write_reg(REG_LEVEL, {15'd0, LVL_MAG, 3'd0, cfg[31:19]});
            repeat (300) @(posedge adc_clk);
            write_reg(REG_CLEAR, '0);
            @(negedge adc_clk);
            check_value("adc_count after clear", adc_count, '0);
        end
        finish_test("level count");

        // about one flag in four
        // report stream stalls at random, reports are far apart so none is lost
        set_stim(32'h4000_0000, 1'b0);
        stat_random = 1'b1;
        write_reg(REG_LEVEL, 32'h0001_0000);
        repeat (300) @(posedge adc_clk);
        finish_test("overflow flag count");

        // rare flags so that some windows fail the mask
        set_stim(32'h0300_0000, 1'b0);
        stat_random = 1'b0;
        for (int i = 0; i < 3; i++)
        begin
            cfg = lcg_step(cfg);
            write_reg(REG_OVFL_MASK, {25'd0, cfg[31:25]});
            repeat (4 * WIN_LEN) @(posedge adc_clk);
        end
        set_stim('0, 1'b0);
        t0 = 0;
        while (rep_q.size() != 0 && t0 < 2 * WIN_LEN)
        begin
            @(posedge adc_clk);
            t0++;
        end
        if (rep_q.size() != 0)
            report_failure("timeout waiting for expected overflow reports");
        finish_test("overflow reports");

        foreach (ratios[i])
        begin
            write_reg(REG_DECIM, ratios[i] - 1);
            wait_accepted(accepted + 6);
        end
        check_value("drop_count with ready high", drop_seen, '0);
        finish_test("decimation");

        // full rate into a randomly stalled FIFO forces drops
        allow_skip = 1'b1;
        write_reg(REG_DECIM, '0);
        set_stim('0, 1'b1);
        repeat (400) @(posedge adc_clk);
        set_stim('0, 1'b0);
        write_reg(REG_DECIM, 32'd15);
        t0 = 0;
        while (sum_q.size() != 0 && t0 < 300)
        begin
            @(posedge adc_clk);
            t0++;
        end
        if (sum_q.size() != 0)
            report_failure("sample FIFO did not drain, model sums still pending");
        // every model sum is now either accepted or counted as dropped
        check_value("accepted plus dropped sums", accepted + drop_seen, made);
        finish_test("back-pressure");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- rx_top.sv
// receiver front end top: ADC monitor, decimator and the two output FIFOs
`include "rx_settings.svh"

module rx_top (
    input  logic                       adc_clk,
    input  logic                       rst_n,
    input  rx_types_pkg::adc_sample_t  adc_data,
    input  logic                       adc_ovfl,
    input  logic                       reg_wr,
    input  rx_regs_pkg::reg_addr_t     reg_addr,
    input  logic [31:0]                reg_wdata,
    output logic                       samp_valid,
    input  logic                       samp_ready,
    output rx_types_pkg::decim_sum_t   samp_data,
    output logic                       stat_valid,
    input  logic                       stat_ready,
    output rx_types_pkg::ovfl_report_t stat_data,
    output logic [31:0]                adc_count,
    output logic [15:0]                drop_count
);
    import rx_types_pkg::*;

    logic         report_valid;
    logic         report_ready;
    ovfl_report_t report_data;
    logic         sum_valid;
    logic         sum_ready;
    decim_sum_t   sum_data;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    adc_monitor mon0 (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .adc_data     (adc_data),
        .adc_ovfl     (adc_ovfl),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .report_ready (report_ready),
        .report_valid (report_valid),
        .report_data  (report_data),
        .adc_count    (adc_count)
    );

    // decimator sees every sample, no handshake on the ADC side
    decim_accum decim0 (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .sum_ready  (sum_ready),
        .sum_valid  (sum_valid),
        .sum_data   (sum_data),
        .drop_count (drop_count)
    );

    //////////////////////////////////////////////////////////////////////
    // output buffering
    //////////////////////////////////////////////////////////////////////

    stream_fifo #(.payload_t(decim_sum_t), .DEPTH(`RX_SAMP_FIFO_DEPTH)) samp_fifo (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .in_valid  (sum_valid),
        .in_data   (sum_data),
        .in_ready  (sum_ready),
        .out_valid (samp_valid),
        .out_data  (samp_data),
        .out_ready (samp_ready)
    );

    stream_fifo #(.payload_t(ovfl_report_t), .DEPTH(`RX_STAT_FIFO_DEPTH)) stat_fifo (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .in_valid  (report_valid),
        .in_data   (report_data),
        .in_ready  (report_ready),
        .out_valid (stat_valid),
        .out_data  (stat_data),
        .out_ready (stat_ready)
    );

endmodule

//--- rx_types_pkg.sv
// data types for samples, decimator sums and overflow window reports
`include "rx_settings.svh"

package rx_types_pkg;

    // raw converter sample, two's complement
    typedef logic signed [`RX_ADC_BITS-1:0] adc_sample_t;

    // magnitude drops the sign bit
    // most negative code saturates to all ones
    typedef logic [`RX_ADC_BITS-2:0] adc_mag_t;

    // log2 of RX_DECIM_MAX guard bits on top of the sample width
    // 16 full scale samples fit without wrap
    typedef logic signed [`RX_ADC_BITS+3:0] decim_sum_t;

    // overflow count over one window
    // one extra bit so a window of all overflows still fits
    typedef logic [`RX_OVFL_WIN_BITS:0] ovfl_cnt_t;

    // one report per window that passes the mask
    typedef struct packed {
        logic [7:0] seq_num;
        ovfl_cnt_t  ovfl_cnt;
    } ovfl_report_t;

endpackage

//--- stream_fifo.sv
// circular buffer FIFO with valid/ready on both sides and a type parameter payload
module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     adc_clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
    localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(DEPTH);

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    // a full FIFO still takes an item when the head leaves this cycle
    assign in_ready  = (count != FULL_CNT) || out_ready;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // storage
    always_ff @(posedge adc_clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule
